//--- rtl/board_pkg.sv
package board_pkg;

  localparam int DATA_W = 32;
  localparam int REG_AW = 4;   // 16 registers
  localparam int ADDR_W = 12;  // apb address, also the immediate width

  typedef enum logic [3:0] {
    OP_LI   = 4'h0,
    OP_ADD  = 4'h1,
    OP_IO   = 4'h7,
    OP_HALT = 4'hA
  } opcode_t;

  // instruction word, msb first
  typedef struct packed {
    logic [ADDR_W-1:0] imm;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rd;
    logic [3:0]        opt;  // reserved
    opcode_t           opcode;
  } instr_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_IO_SETUP,
    ST_IO_ACCESS,
    ST_HALT
  } cpu_state_t;

endpackage

//--- rtl/instr_rom.sv
`timescale 1ns/1ps

module instr_rom import board_pkg::*; #(
  parameter int  ROM_DEPTH = 64,
  localparam int PC_W      = $clog2(ROM_DEPTH)
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            run,
  input  apb_req_t        prog,
  output logic            prog_pready,
  input  logic [PC_W-1:0] pc,
  output instr_t          instr
);

  logic [DATA_W-1:0] mem [ROM_DEPTH];
  logic              prog_wr;

  // loading only while the cpu is stopped
  assign prog_wr     = prog.psel && prog.penable && prog.pwrite && !run;
  assign prog_pready = 1'b1;  // zero wait states

  always_ff @(posedge clk) begin
    if (prog_wr) begin
      mem[prog.paddr[PC_W-1:0]] <= prog.pwdata;
    end
  end

  // fetch port, one cycle latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr <= '0;
    end else begin
      instr <= instr_t'(mem[pc]);
    end
  end

  // the loader must finish before run is raised
  a_no_prog_while_run: assert property (@(posedge clk) disable iff (!rst_n)
    prog.psel && prog.penable && prog.pwrite |-> !run);

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import board_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_idx,
  input  logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] rd1,
  output logic [DATA_W-1:0] rd2
);

  localparam int NREG = 1 << REG_AW;

  logic [DATA_W-1:0] x [NREG];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NREG; i++) begin
        x[i] <= '0;
      end
    end else if (wr_en) begin
      x[wr_idx] <= wr_data;
    end
  end

  // read ports see the old value during a write
  assign rd1 = x[rs1];
  assign rd2 = x[rs2];

endmodule

//--- rtl/cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl import board_pkg::*; #(
  parameter int  ROM_DEPTH = 64,
  localparam int PC_W      = $clog2(ROM_DEPTH)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  output logic [PC_W-1:0]   pc,
  input  instr_t            instr,
  output logic [REG_AW-1:0] rs1,
  output logic [REG_AW-1:0] rs2,
  input  logic [DATA_W-1:0] rd1,
  input  logic [DATA_W-1:0] rd2,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_idx,
  output logic [DATA_W-1:0] wr_data,
  output apb_req_t          io_req,
  input  logic              io_pready,
  output logic              halted
);

  cpu_state_t        state;
  cpu_state_t        state_nxt;
  logic [ADDR_W-1:0] io_addr;
  logic [DATA_W-1:0] io_data;
  logic              io_sel;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:      if (run) state_nxt = ST_FETCH;
      ST_FETCH:     state_nxt = ST_EXEC;
      ST_EXEC: begin
        case (instr.opcode)
          OP_IO:   state_nxt = ST_IO_SETUP;
          OP_HALT: state_nxt = ST_HALT;
          default: state_nxt = ST_FETCH;  // li, add, no-op
        endcase
      end
      ST_IO_SETUP:  state_nxt = ST_IO_ACCESS;
      ST_IO_ACCESS: if (io_pready) state_nxt = ST_FETCH;
      default:      state_nxt = ST_HALT;  // stuck until reset
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      pc    <= '0;
    end else begin
      state <= state_nxt;
      // rom samples the old pc on this same edge
      if (state == ST_FETCH) begin
        pc <= (pc == PC_W'(ROM_DEPTH - 1)) ? '0 : pc + 1'b1;
      end
    end
  end

  // instr moves on after exec, so keep the io operands
  always_ff @(posedge clk) begin
    if (state == ST_EXEC && instr.opcode == OP_IO) begin
      io_addr <= instr.imm;
      io_data <= rd1;
    end
  end

  assign rs1    = instr.rs1;
  assign rs2    = instr.rs2;
  assign wr_idx = instr.rd;

  always_comb begin
    wr_en   = 1'b0;
    wr_data = '0;
    if (state == ST_EXEC) begin
      case (instr.opcode)
        OP_LI: begin
          wr_en   = 1'b1;
          wr_data = DATA_W'(instr.imm);  // zero extended
        end
        OP_ADD: begin
          wr_en   = 1'b1;
          wr_data = rd1 + rd2;
        end
        default: ;
      endcase
    end
  end

  assign io_sel = (state == ST_IO_SETUP) || (state == ST_IO_ACCESS);

  always_comb begin
    io_req.psel    = io_sel;
    io_req.penable = (state == ST_IO_ACCESS);
    io_req.pwrite  = io_sel;  // write only
    io_req.paddr   = io_addr;
    io_req.pwdata  = io_data;
  end

  assign halted = (state == ST_HALT);

  a_io_hold: assert property (@(posedge clk) disable iff (!rst_n)
    io_req.psel && io_req.penable && !io_pready |=> $stable(io_req));

endmodule

//--- rtl/baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
  parameter int  WAIT = 4,
  localparam int CW   = (WAIT > 1) ? $clog2(WAIT) : 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic bit_end,
  output logic frame_end
);

  logic          active;
  logic [CW-1:0] clk_cnt;
  logic [3:0]    bit_cnt;  // start, 8 data, stop

  assign bit_end   = active && (clk_cnt == CW'(WAIT - 1));
  assign frame_end = bit_end && (bit_cnt == 4'd9);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (start) begin
      // wins over frame_end for back-to-back frames
      active  <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (bit_end) begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      if (frame_end) active <= 1'b0;
    end else if (active) begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // a new frame never cuts into a running one
  a_start_clean: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !active || frame_end);

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import board_pkg::*; #(
  parameter int WAIT = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t io_req,
  output logic     io_pready,
  output logic     tx,
  output logic     busy
);

  logic       access;
  logic       addr_hit;
  logic       load;
  logic       bit_end;
  logic       frame_end;
  logic [9:0] shift;  // lsb is on the line

  assign access   = io_req.psel && io_req.penable;
  assign addr_hit = (io_req.paddr == '0);

  // last stop-bit cycle may already take the next byte
  assign io_pready = access && (!addr_hit || !busy || frame_end);
  assign load      = io_pready && addr_hit && io_req.pwrite;

  baud_timer #(
    .WAIT(WAIT)
  ) timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (load),
    .bit_end  (bit_end),
    .frame_end(frame_end)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift <= '1;  // idle line high
      busy  <= 1'b0;
    end else if (load) begin
      shift <= {1'b1, io_req.pwdata[7:0], 1'b0};
      busy  <= 1'b1;
    end else if (bit_end) begin
      shift <= {1'b1, shift[9:1]};  // ones fill behind the stop bit
      if (frame_end) busy <= 1'b0;
    end
  end

  assign tx = shift[0];

  // the next byte waits for the last cycle of the frame
  a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    load |=> !(access && addr_hit && io_pready) [*(10 * WAIT - 1)]);

  // every accepted byte holds the transmitter for a whole frame
  a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
    load |=> busy [*(10 * WAIT)]);

endmodule

//--- rtl/mother_board.sv
`timescale 1ns/1ps

module mother_board import board_pkg::*; #(
  parameter int WAIT      = 4,
  parameter int ROM_DEPTH = 64
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,
  input  apb_req_t prog,
  output logic     prog_pready,
  output logic     uart_tx,
  output logic     tx_busy,
  output logic     halted
);

  localparam int PC_W = $clog2(ROM_DEPTH);

  logic [PC_W-1:0]   pc;
  instr_t            instr;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [DATA_W-1:0] rd1;
  logic [DATA_W-1:0] rd2;
  logic              wr_en;
  logic [REG_AW-1:0] wr_idx;
  logic [DATA_W-1:0] wr_data;
  apb_req_t          io_req;
  logic              io_pready;

  instr_rom #(
    .ROM_DEPTH(ROM_DEPTH)
  ) rom (
    .clk, .rst_n, .run, .prog, .prog_pready, .pc, .instr
  );

  reg_file gr_file (
    .clk, .rst_n, .rs1, .rs2, .wr_en, .wr_idx, .wr_data, .rd1, .rd2
  );

  cpu_ctrl #(
    .ROM_DEPTH(ROM_DEPTH)
  ) cpu (
    .clk, .rst_n, .run, .pc, .instr,
    .rs1, .rs2, .rd1, .rd2,
    .wr_en, .wr_idx, .wr_data,
    .io_req, .io_pready, .halted
  );

  // io address 0 is the uart data register
  uart_tx #(
    .WAIT(WAIT)
  ) transmitter (
    .clk      (clk),
    .rst_n    (rst_n),
    .io_req   (io_req),
    .io_pready(io_pready),
    .tx       (uart_tx),
    .busy     (tx_busy)
  );

endmodule

//--- testbench/tb_mother_board.sv
`timescale 1ns/1ps

module tb_mother_board import board_pkg::*;;

  localparam int WAIT      = 4;
  localparam int ROM_DEPTH = 64;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     run;
  apb_req_t prog;
  logic     prog_pready;
  logic     uart_tx;
  logic     tx_busy;
  logic     halted;

  logic [31:0] prog_q [$];
  logic [7:0]  exp_q [$];
  logic [3:0]  nop_ops [12] = '{4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h8,
                                4'h9, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
  int          n_io;
  int          n_exp;
  int          frames_seen;
  int          busy_falls;
  logic        busy_seen;
  int          wd_limit;
  int          wd_count;
  logic        wd_on = 1'b0;

  mother_board #(
    .WAIT     (WAIT),
    .ROM_DEPTH(ROM_DEPTH)
  ) mother_board_inst (
    .clk, .rst_n, .run, .prog, .prog_pready, .uart_tx, .tx_busy, .halted
  );

  always #4 clk = ~clk;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  function automatic logic [31:0] encode(logic [3:0] op, logic [3:0] rd,
                                         logic [3:0] rs1, logic [3:0] rs2,
                                         logic [11:0] imm);
    return {imm, rs2, rs1, rd, 4'h0, op};
  endfunction

  // mixed adds io writes to other addresses and unknown opcodes
  task automatic add_random_body(int n, bit mixed);
    int          sel;
    logic [11:0] addr;
    for (int i = 0; i < n; i++) begin
      sel = $urandom_range(0, 9);
      if (sel < 4 || (sel == 9 && !mixed)) begin
        prog_q.push_back(encode(OP_LI, 4'($urandom), 4'h0, 4'h0, 12'($urandom)));
      end else if (sel < 7) begin
        prog_q.push_back(encode(OP_ADD, 4'($urandom), 4'($urandom), 4'($urandom), 12'h0));
      end else if (sel < 9) begin
        addr = (mixed && $urandom_range(0, 2) == 0) ? 12'($urandom_range(1, 4095)) : 12'h0;
        prog_q.push_back(encode(OP_IO, 4'h0, 4'($urandom), 4'h0, addr));
      end else begin
        prog_q.push_back(encode(nop_ops[$urandom_range(0, 11)], 4'($urandom),
                                4'($urandom), 4'($urandom), 12'($urandom)));
      end
    end
  endtask

  // instruction-set model, queues the expected line bytes
  task automatic model_program();
    logic [31:0] regs [16];
    logic [31:0] w;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    for (int r = 0; r < 16; r++) regs[r] = '0;
    exp_q.delete();
    n_io = 0;
    foreach (prog_q[i]) begin
      w   = prog_q[i];
      rd  = w[11:8];
      rs1 = w[15:12];
      rs2 = w[19:16];
      if (w[3:0] == 4'hA) break;
      case (w[3:0])
        4'h0: regs[rd] = {20'h0, w[31:20]};
        4'h1: regs[rd] = regs[rs1] + regs[rs2];
        4'h7: begin
          n_io++;
          if (w[31:20] == 12'h0) exp_q.push_back(regs[rs1][7:0]);
        end
        default: ;  // no-op
      endcase
    end
    n_exp = exp_q.size();
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_q.size(); i++) begin
      @(posedge clk);
      #1;
      prog.psel    = 1'b1;
      prog.penable = 1'b0;
      prog.pwrite  = 1'b1;
      prog.paddr   = 12'(i);
      prog.pwdata  = prog_q[i];
      @(posedge clk);
      #1;
      prog.penable = 1'b1;
      @(negedge clk);
      check_value("prog_pready", prog_pready, 1);
    end
    @(posedge clk);
    #1;
    prog = '0;
  endtask

  task automatic run_program(bit back_to_back);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    run   = 1'b0;
    prog  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("uart_tx", uart_tx, 1);
    check_value("tx_busy", tx_busy, 0);
    check_value("halted", halted, 0);
    load_program();
    model_program();
    frames_seen = 0;
    busy_falls  = 0;
    wd_limit    = prog_q.size() * 2 + n_io * (10 * WAIT + 4) + 100;
    wd_count    = 0;
    wd_on       = 1'b1;
    run         = 1'b1;  // still 1 ns after the edge
    do @(negedge clk); while (!halted);
    do @(negedge clk); while (tx_busy);
    repeat (2) @(negedge clk);
    wd_on = 1'b0;
    check_value("frame count", frames_seen, n_exp);
    check_value("halted", halted, 1);
    check_value("uart_tx", uart_tx, 1);
    if (back_to_back) check_value("tx_busy falls", busy_falls, 1);
  endtask

  // sample each bit in its middle, on the falling clock
  task automatic receive_frame();
    logic [7:0] data;
    repeat (WAIT / 2) @(negedge clk);
    check_value("uart_tx start bit", uart_tx, 0);
    for (int b = 0; b < 8; b++) begin
      repeat (WAIT) @(negedge clk);
      data[b] = uart_tx;
    end
    repeat (WAIT) @(negedge clk);
    check_value("uart_tx stop bit", uart_tx, 1);
    frames_seen++;
    if (exp_q.size() == 0) begin
      abort_run("a frame arrived on the line while no byte was expected");
    end
    check_value("uart_tx byte", data, exp_q.pop_front());
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) receive_frame();
    end
  end

  always @(negedge clk) begin
    if (wd_on && busy_seen && !tx_busy) busy_falls++;
    busy_seen = tx_busy;
  end

  always @(posedge clk) begin
    if (wd_on) begin
      wd_count++;
      if (wd_count > wd_limit) abort_run("watchdog: the program did not finish in time");
    end
  end

  initial begin
    rst_n = 1'b0;
    run   = 1'b0;
    prog  = '0;
    void'($urandom(57389));

    // one byte, then halt
    prog_q.delete();
    prog_q.push_back(encode(OP_LI, 4'h1, 4'h0, 4'h0, 12'h05A));
    prog_q.push_back(encode(OP_IO, 4'h0, 4'h1, 4'h0, 12'h000));
    prog_q.push_back(encode(OP_HALT, 4'h0, 4'h0, 4'h0, 12'h000));
    run_program(1'b0);

    // arithmetic
    prog_q.delete();
    for (int r = 1; r < 5; r++) begin
      prog_q.push_back(encode(OP_LI, 4'(r), 4'h0, 4'h0, 12'($urandom)));
    end
    add_random_body(16, 1'b0);
    for (int k = 0; k < 3; k++) begin
      prog_q.push_back(encode(OP_IO, 4'h0, 4'($urandom), 4'h0, 12'h000));
    end
    prog_q.push_back(encode(OP_HALT, 4'h0, 4'h0, 4'h0, 12'h000));
    run_program(1'b0);

    // io writes back to back
    prog_q.delete();
    for (int r = 1; r < 5; r++) begin
      prog_q.push_back(encode(OP_LI, 4'(r), 4'h0, 4'h0, 12'($urandom)));
    end
    for (int r = 1; r < 5; r++) begin
      prog_q.push_back(encode(OP_IO, 4'h0, 4'(r), 4'h0, 12'h000));
    end
    prog_q.push_back(encode(OP_HALT, 4'h0, 4'h0, 4'h0, 12'h000));
    run_program(1'b1);

    // other io addresses and unknown opcodes
    prog_q.delete();
    prog_q.push_back(encode(OP_LI, 4'h2, 4'h0, 4'h0, 12'h033));
    prog_q.push_back(encode(OP_IO, 4'h0, 4'h2, 4'h0, 12'h005));
    prog_q.push_back(encode(4'h3, 4'h2, 4'h2, 4'h2, 12'hFFF));
    prog_q.push_back(encode(OP_IO, 4'h0, 4'h2, 4'h0, 12'hFFF));
    prog_q.push_back(encode(OP_LI, 4'h3, 4'h0, 4'h0, 12'h044));
    prog_q.push_back(encode(4'hF, 4'h3, 4'h1, 4'h1, 12'h123));
    prog_q.push_back(encode(OP_ADD, 4'h4, 4'h2, 4'h3, 12'h000));
    prog_q.push_back(encode(OP_IO, 4'h0, 4'h4, 4'h0, 12'h000));
    prog_q.push_back(encode(OP_HALT, 4'h0, 4'h0, 4'h0, 12'h000));
    run_program(1'b0);

    for (int t = 0; t < 5; t++) begin
      prog_q.delete();
      add_random_body($urandom_range(10, 40), 1'b1);
      prog_q.push_back(encode(OP_HALT, 4'h0, 4'h0, 4'h0, 12'h000));
      run_program(1'b0);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- list.f
rtl/board_pkg.sv
rtl/instr_rom.sv
rtl/reg_file.sv
rtl/cpu_ctrl.sv
rtl/baud_timer.sv
rtl/uart_tx.sv
rtl/mother_board.sv
testbench/tb_mother_board.sv
